// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the execute core testbench with Verilator, run it and look for the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module exec_core_tb -o exec_core_sim

# A stopped simulation still prints what it produced. The search below decides.
sim_out="$(./obj_dir/exec_core_sim 2>&1)" || true
echo "$sim_out"

if grep -qx "TEST PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== source/alu.sv ====
// alu: 32-bit add/sub, logic, shifts and set-less-than
module alu
    import rv_exec_pkg::*;
(
    input  logic [3:0]      operation,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;   // low five bits of b
    logic       lt_s;    // signed compare
    logic       lt_u;    // unsigned compare

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (operation)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_XOR: result = a ^ b;
            ALU_OR:  result = a | b;
            ALU_AND: result = a & b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = $unsigned($signed(a) >>> shamt);  // keeps sign bit
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_u};
            end
            default: result = '0;  // unused codes
        endcase
    end

endmodule

// ==== source/alu_control.sv ====
// alu control: alu-op class, funct3 and funct7 to a 4-bit alu operation and an encoding error
module alu_control
    import rv_exec_pkg::*;
(
    input  logic [1:0] ula_op,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output logic [3:0] operation,
    output logic       err
);

    // operation implied by funct3 alone, alt forms handled by the caller
    function automatic logic [3:0] base_op(input logic [2:0] f3);
        logic [3:0] op;
        case (f3)
            3'b000:  op = ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;   // 3'b111
        endcase
        return op;
    endfunction

    always_comb begin
        operation = ALU_ADD;  // defined on every path, no latch
        err       = 1'b0;

        case (ula_op)
            ULA_ADD: operation = ALU_ADD;
            ULA_SUB: operation = ALU_SUB;

            ULA_RTYPE: begin
                operation = base_op(funct3);
                if (funct7 == FUNCT7_ALT) begin
                    // only sub and sra have an alternate form
                    if (funct3 == 3'b000) begin
                        operation = ALU_SUB;
                    end else if (funct3 == 3'b101) begin
                        operation = ALU_SRA;
                    end else begin
                        err = 1'b1;
                    end
                end else if (funct7 != 7'b0) begin
                    err = 1'b1;  // reserved funct7
                end
            end

            default: begin  // ULA_ITYPE
                operation = base_op(funct3);
                case (funct3)
                    3'b001: begin
                        err = (funct7 != 7'b0);  // slli
                    end
                    3'b101: begin
                        if (funct7 == FUNCT7_ALT) begin
                            operation = ALU_SRA;  // srai
                        end else if (funct7 != 7'b0) begin
                            err = 1'b1;
                        end
                    end
                    default: err = 1'b0;  // upper bits are plain immediate
                endcase
            end
        endcase

        if (err) begin
            operation = ALU_ADD;
        end
    end

endmodule

// ==== source/exec_core.sv ====
// execute core: accepts one instruction, reads operands, runs the alu, writes back, reports result
module exec_core
    import rv_exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  instr_t                in_instr,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [REG_ADDR_W-1:0] out_rd,
    output logic [XLEN-1:0]       out_result,
    output logic                  out_err
);

    logic            in_fire;     // input transfer this cycle
    logic [1:0]      ula_op;
    logic            use_imm;
    logic            reg_write;
    logic            illegal;     // unsupported opcode
    logic [3:0]      operation;
    logic            ctrl_err;    // bad funct7 / shift imm
    logic            instr_err;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            wr_en;

    // output slot frees up when empty or being drained
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    main_decoder main_decoder_inst (
        .opcode    (in_instr.r.opcode),
        .ula_op    (ula_op),
        .use_imm   (use_imm),
        .reg_write (reg_write),
        .illegal   (illegal)
    );

    // for i-type the funct7 slot carries imm[11:5]
    alu_control alu_control_inst (
        .ula_op    (ula_op),
        .funct3    (in_instr.r.funct3),
        .funct7    (in_instr.r.funct7),
        .operation (operation),
        .err       (ctrl_err)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (in_instr.r.rs1),
        .rs2_addr (in_instr.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (in_instr.r.rd),
        .wr_data  (alu_result)
    );

    assign imm_ext   = {{(XLEN-12){in_instr.i.imm[11]}}, in_instr.i.imm};  // sign extend
    assign operand_b = use_imm ? imm_ext : rs2_data;

    alu alu_inst (
        .operation (operation),
        .a         (rs1_data),
        .b         (operand_b),
        .result    (alu_result)
    );

    assign instr_err = illegal || ctrl_err;
    assign wr_en     = reg_write && !instr_err && in_fire;  // write at acceptance edge

    // output valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // drained, nothing new
        end
    end

    // output payload, held while stalled
    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_rd     <= in_instr.r.rd;
            out_result <= instr_err ? '0 : alu_result;
            out_err    <= instr_err;
        end
    end

endmodule

// ==== source/main_decoder.sv ====
// main decoder: opcode to alu-op class, operand select, write enable and illegal flag
module main_decoder
    import rv_exec_pkg::*;
(
    input  logic [6:0] opcode,
    output logic [1:0] ula_op,
    output logic       use_imm,
    output logic       reg_write,
    output logic       illegal
);

    always_comb begin
        // safe defaults for anything unsupported
        ula_op    = ULA_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        illegal   = 1'b1;

        case (opcode)
            OPCODE_OP: begin
                ula_op    = ULA_RTYPE;  // funct3 and funct7 decide
                use_imm   = 1'b0;       // rs2 as operand b
                reg_write = 1'b1;
                illegal   = 1'b0;
            end
            OPCODE_OP_IMM: begin
                ula_op    = ULA_ITYPE;  // upper imm only checked on shifts
                use_imm   = 1'b1;       // sign-extended imm as operand b
                reg_write = 1'b1;
                illegal   = 1'b0;
            end
            default: begin
                // loads, stores, branches, lui etc. not handled here
                ula_op    = ULA_ADD;
                use_imm   = 1'b0;
                reg_write = 1'b0;
                illegal   = 1'b1;
            end
        endcase
    end

endmodule

// ==== source/register_file.sv ====
// register file: 32 x 32-bit, two async read ports, one sync write port, x0 fixed at zero
module register_file
    import rv_exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic [XLEN-1:0]       wr_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;  // architectural state starts at zero
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // x0 writes dropped
        end
    end

    // x0 always reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/rv_exec_pkg.sv ====
// rv32i execute package: widths, opcodes, alu-op classes, alu operations, instruction word
package rv_exec_pkg;

    localparam int XLEN       = 32;   // data width
    localparam int REG_ADDR_W = 5;    // register index width

    // supported major opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;  // r-type arithmetic
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;  // i-type arithmetic

    // alu-op class from the main decoder
    localparam logic [1:0] ULA_ADD   = 2'b00;  // force add
    localparam logic [1:0] ULA_SUB   = 2'b01;  // force sub
    localparam logic [1:0] ULA_RTYPE = 2'b10;  // decode funct3 and funct7
    localparam logic [1:0] ULA_ITYPE = 2'b11;  // decode funct3, upper imm only for shifts

    // alu operation codes
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_XOR  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_AND  = 4'd4;
    localparam logic [3:0] ALU_SLL  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_SLT  = 4'd8;
    localparam logic [3:0] ALU_SLTU = 4'd9;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // selects sub and sra

    // one instruction word, seen as r-type or i-type fields
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } instr_t;

endpackage

// ==== test/exec_core_checker.sv ====
// execute core checker: reference register file and alu, compares every output transfer
module exec_core_checker
    import rv_exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  instr_t                in_instr,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic [REG_ADDR_W-1:0] out_rd,
    input  logic [XLEN-1:0]       out_result,
    input  logic                  out_err,
    output int                    mismatch_count,
    output int                    extra_count,
    output int                    pending_count
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [XLEN-1:0] model_regs [32];
    logic [37:0]     expected_q [$];   // {err, rd, result}
    int              mismatches = 0;
    int              extras     = 0;
    int              pending    = 0;

    assign mismatch_count = mismatches;
    assign extra_count    = extras;
    assign pending_count  = pending;

    // rv32i integer semantics by funct3, alt selects sub / sra
    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [XLEN-1:0] y;
        logic [4:0]      sh;
        sh = b[4:0];
        case (f3)
            3'b000:  y = alt ? (a - b) : (a + b);
            3'b001:  y = a << sh;
            3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  y = (a < b) ? 32'd1 : 32'd0;
            3'b100:  y = a ^ b;
            3'b101:  y = (a >> sh) | ((alt && a[31]) ? ~({XLEN{1'b1}} >> sh) : '0);
            3'b110:  y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // expected result and error flag for one instruction against the model registers
    task automatic predict(input instr_t ins, output logic [XLEN-1:0] res, output logic bad);
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic            alt;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        f3  = ins.r.funct3;
        f7  = ins.r.funct7;
        alt = (f7 == FUNCT7_ALT);
        a   = model_regs[ins.r.rs1];
        b   = '0;
        res = '0;
        bad = 1'b0;
        if (ins.r.opcode == OPCODE_OP) begin
            b   = model_regs[ins.r.rs2];
            bad = !(f7 == 7'b0 || (alt && (f3 == 3'b000 || f3 == 3'b101)));
        end else if (ins.r.opcode == OPCODE_OP_IMM) begin
            b = {{(XLEN-12){ins.i.imm[11]}}, ins.i.imm};
            if (f3 == 3'b001) begin
                bad = (f7 != 7'b0);
            end else if (f3 == 3'b101) begin
                bad = !(f7 == 7'b0 || alt);
            end else begin
                alt = 1'b0;  // upper bits are plain immediate here
            end
        end else begin
            bad = 1'b1;  // unsupported opcode
        end
        if (!bad) begin
            res = alu_model(f3, alt, a, b);
        end
    endtask

    always @(posedge clk) begin
        logic [XLEN-1:0] res;
        logic            bad;
        logic [37:0]     expected;
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            expected_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    extras++;
                    $display("output transfer at %0t ns with no instruction outstanding", $time);
                end else begin
                    expected = expected_q.pop_front();
                    if (out_rd !== expected[36:32]) begin
                        mismatches++;
                        $display("ERROR at %0t ns: rd expected %0d got %0d",
                                 $time, expected[36:32], out_rd);
                    end
                    if (out_result !== expected[31:0]) begin
                        mismatches++;
                        $display("ERROR at %0t ns: result expected %08h got %08h",
                                 $time, expected[31:0], out_result);
                    end
                    if (out_err !== expected[37]) begin
                        mismatches++;
                        $display("ERROR at %0t ns: err expected %0b got %0b",
                                 $time, expected[37], out_err);
                    end
                end
            end
            if (in_valid && in_ready) begin
                predict(in_instr, res, bad);
                expected_q.push_back({bad, in_instr.r.rd, res});
                if (!bad && in_instr.r.rd != 5'd0) begin
                    model_regs[in_instr.r.rd] = res;  // seen by the next instruction
                end
            end
        end
        pending = expected_q.size();
    end

endmodule

// ==== test/exec_core_sva.sv ====
// execute core assertions: reset of the output slot, output hold under stall, ready rule
module exec_core_sva
    import rv_exec_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic [REG_ADDR_W-1:0] out_rd,
    input logic [XLEN-1:0]       out_result,
    input logic                  out_err
);

    timeunit 1ns;
    timeprecision 1ps;

    // sync reset empties the output slot
    reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid still high in the cycle after reset");

    output_holds: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_rd) && $stable(out_result) && $stable(out_err)))
        else $error("output changed or dropped while stalled by out_ready");

    ready_rule: assert property (@(posedge clk) disable iff (rst)
        in_ready == (!out_valid || out_ready))
        else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind exec_core exec_core_sva exec_core_sva_inst (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_rd     (out_rd),
    .out_result (out_result),
    .out_err    (out_err)
);

// ==== test/exec_core_tb.sv ====
// execute core testbench: clock, reset, seeded random instructions and output back-pressure
module exec_core_tb
    import rv_exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR  = 400;
    localparam int WAIT_LIMIT = 50;   // cycles

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    instr_t                in_instr;
    logic                  out_valid;
    logic                  out_ready;
    logic [REG_ADDR_W-1:0] out_rd;
    logic [XLEN-1:0]       out_result;
    logic                  out_err;
    int                    mismatch_count;
    int                    extra_count;
    int                    pending_count;
    int                    timeouts = 0;
    int                    seed     = 14186;

    always #4 clk = ~clk;  // 8 ns period

    exec_core exec_core_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_rd     (out_rd),
        .out_result (out_result),
        .out_err    (out_err)
    );

    exec_core_checker exec_core_checker_inst (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_instr       (in_instr),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_rd         (out_rd),
        .out_result     (out_result),
        .out_err        (out_err),
        .mismatch_count (mismatch_count),
        .extra_count    (extra_count),
        .pending_count  (pending_count)
    );

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // mostly legal op / op-imm, some reserved funct7, bad shift imm or unknown opcode
    function automatic instr_t make_instr();
        logic [31:0] r;
        logic [31:0] r2;
        logic [6:0]  op;
        logic [6:0]  f7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [4:0]  rd;
        r   = next_rand();
        r2  = next_rand();
        op  = OPCODE_OP;
        f7  = 7'b0;
        f3  = r[6:4];
        rd  = {1'b0, r[10:7]};   // x0..x15 so results get reused
        rs1 = {1'b0, r[14:11]};
        rs2 = {1'b0, r[18:15]};
        if (r[3:0] < 4'd6 || r[3:0] == 4'd14) begin
            if ((f3 == 3'b000 || f3 == 3'b101) && r[19]) begin
                f7 = FUNCT7_ALT;  // sub / sra
            end
            if (r[3:0] == 4'd14) begin
                rd = 5'd0;  // write to x0
            end
        end else if (r[3:0] < 4'd11 || r[3:0] == 4'd15) begin
            op  = OPCODE_OP_IMM;
            f7  = r2[11:5];
            rs2 = r2[4:0];
            if (f3 == 3'b001) begin
                f7 = 7'b0;
            end else if (f3 == 3'b101) begin
                f7 = r[19] ? FUNCT7_ALT : 7'b0;
            end else if (f3 == 3'b000 && r[20]) begin
                f7 = FUNCT7_ALT;  // addi with sub-like upper bits
            end
            if (r[3:0] == 4'd15) begin
                rs1 = 5'd0;
            end
        end else if (r[3:0] == 4'd11) begin
            f7 = (r2[6:0] == 7'b0) ? 7'b0000001 : r2[6:0];  // reserved funct7
            if (f7 == FUNCT7_ALT) begin
                f3 = 3'b111;
            end
        end else if (r[3:0] == 4'd12) begin
            op = OPCODE_OP_IMM;
            f3 = r[19] ? 3'b101 : 3'b001;
            f7 = (r2[6:0] == 7'b0) ? 7'b0000010 : r2[6:0];  // bad shift imm
            if (f7 == FUNCT7_ALT && f3 == 3'b101) begin
                f7 = 7'b1100000;
            end
        end else begin
            op = r2[6:0];
            if (op == OPCODE_OP || op == OPCODE_OP_IMM) begin
                op = 7'b0000011;
            end
        end
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    task automatic randomize_out_ready();
        logic [31:0] r;
        r = next_rand();
        out_ready = (r % 3) != 0;  // low about a third of the time
    endtask

    // two cycles of sync reset, then idle cycles in which no result may come out
    task automatic apply_reset();
        in_valid = 1'b0;
        rst      = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst       = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
    endtask

    // hold the instruction until in_ready is seen at an edge
    task automatic send_instr(input instr_t ins, output bit ok);
        int waited;
        bit taken;
        in_valid = 1'b1;
        in_instr = ins;
        waited   = 0;
        taken    = 1'b0;
        ok       = 1'b1;
        while (!taken && ok) begin
            randomize_out_ready();
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited >= WAIT_LIMIT) begin
                $display("in_ready stayed low for %0d cycles, stopped at %0t ns", waited, $time);
                timeouts++;
                ok = 1'b0;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs(output bit ok);
        int waited;
        out_ready = 1'b1;
        waited    = 0;
        ok        = 1'b1;
        while ((pending_count != 0 || out_valid) && ok) begin
            @(posedge clk);
            #1;
            waited++;
            if ((pending_count != 0 || out_valid) && waited >= WAIT_LIMIT) begin
                $display("%0d results never came out after %0d cycles", pending_count, waited);
                timeouts++;
                ok = 1'b0;
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        bit          ok;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b1;
        ok        = 1'b1;
        apply_reset();
        for (int n = 0; n < NUM_INSTR && ok; n++) begin
            if (n == NUM_INSTR / 2) begin
                out_ready = 1'b0;  // last result still stalled when reset hits
                apply_reset();
            end
            send_instr(make_instr(), ok);
            r = next_rand();
            if (ok && r[2:0] == 3'd0) begin
                randomize_out_ready();  // bubble on the input
                @(posedge clk);
                #1;
            end
        end
        if (ok) begin
            drain_outputs(ok);
        end
        $display("mismatches=%0d unexpected_outputs=%0d missing_outputs=%0d timeouts=%0d",
                 mismatch_count, extra_count, pending_count, timeouts);
        if (mismatch_count == 0 && extra_count == 0 && pending_count == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/rv_exec_pkg.sv
source/main_decoder.sv
source/alu_control.sv
source/alu.sv
source/register_file.sv
source/exec_core.sv
test/exec_core_sva.sv
test/exec_core_checker.sv
test/exec_core_tb.sv
